/* board_ctrl_top.f */
hdl/board_pkg.sv
hdl/key_debouncer.sv
hdl/reset_ctrl.sv
hdl/event_counter.sv
hdl/seg7_encoder.sv
hdl/board_ctrl_top.sv
verification/board_ctrl_tb.sv

/* hdl/board_ctrl_top.sv */
// ==================================================================
// Board control top level
// Debounces the four push keys, builds the system reset from the
// external reset, key 3 and the PLL lock, and runs a key-driven
// event counter shown on the six hex displays
// ==================================================================

`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top #(
  parameter int DEBOUNCE_CYCLES = 500000
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                pll_locked,
  input  wire  [board_pkg::NUM_KEYS-1:0]     key,
  input  board_pkg::switch_t                 sw,
  output board_pkg::seg_t                    hex0,
  output board_pkg::seg_t                    hex1,
  output board_pkg::seg_t                    hex2,
  output board_pkg::seg_t                    hex3,
  output board_pkg::seg_t                    hex4,
  output board_pkg::seg_t                    hex5,
  output logic [9:0]                         ledr
);

  import board_pkg::*;

  logic [NUM_KEYS-1:0] key_level;
  logic [NUM_KEYS-1:0] key_fall;
  logic                sys_rst_n;
  count_t              count;
  seg_t                seg [NUM_DIGITS];

  // ==================================================================
  // Key debouncers, on the external reset since key 3 is a reset
  // ==================================================================
  for (genvar k = 0; k < NUM_KEYS; k++) begin : gen_key
    key_debouncer #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_key_debouncer (
      .clk       (clk),
      .rst_n     (rst_n),
      .key_raw   (key[k]),
      .key_level (key_level[k]),
      .key_rise  (),
      .key_fall  (key_fall[k])
    );
  end

  reset_ctrl i_reset_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .button_rst_n (key_level[3]),
    .pll_locked   (pll_locked),
    .sys_rst_n    (sys_rst_n)
  );

  // Key 0 counts up, key 1 down, key 2 loads the switches
  event_counter i_event_counter (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .inc        (key_fall[0]),
    .dec        (key_fall[1]),
    .load       (key_fall[2]),
    .load_value (sw),
    .count      (count)
  );

  // ==================================================================
  // Hex displays, digit 0 is the low nibble
  // ==================================================================
  for (genvar d = 0; d < NUM_DIGITS; d++) begin : gen_digit
    seg7_encoder i_seg7_encoder (
      .digit (count[d*DIGIT_W +: DIGIT_W]),
      .seg   (seg[d])
    );
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

  // Reset state on LED 0, pressed keys 0 to 2 on LEDs 1 to 3
  assign ledr[0]   = sys_rst_n;
  assign ledr[3:1] = ~key_level[2:0];
  assign ledr[9:4] = '0;

endmodule : board_ctrl_top

`default_nettype wire

/* hdl/board_pkg.sv */
// ==================================================================
// Board control shared types
// Vector widths for the counter, display digits, seven-segment
// patterns and slide switches, plus the key debouncer state type
// ==================================================================

`default_nettype none

package board_pkg;

  // Board geometry
  localparam int NUM_KEYS   = 4;
  localparam int NUM_DIGITS = 6;

  // Field widths
  localparam int DIGIT_W  = 4;
  localparam int SEG_W    = 7;
  localparam int SWITCH_W = 10;
  localparam int COUNT_W  = NUM_DIGITS * DIGIT_W;

  // Event counter value, one nibble per display digit
  typedef logic [COUNT_W-1:0] count_t;

  // One hex digit as shown on a display
  typedef logic [DIGIT_W-1:0] digit_t;

  // Active-low segments, bit 0 is segment a, bit 6 is segment g
  typedef logic [SEG_W-1:0] seg_t;

  // Slide switches SW[9:0]
  typedef logic [SWITCH_W-1:0] switch_t;

  // Debouncer FSM
  typedef enum logic {
    dbc_stable,
    dbc_settling
  } dbc_state_t;

endpackage : board_pkg

`default_nettype wire

/* hdl/event_counter.sv */
// ==================================================================
// Key event counter
// 24-bit counter stepped by key-press pulses, with load from the
// slide switches taking priority over increment and decrement
// ==================================================================

`timescale 1ns/1ps
`default_nettype none

module event_counter (
  input  wire                clk,
  input  wire                sys_rst_n,
  input  wire                inc,
  input  wire                dec,
  input  wire                load,
  input  board_pkg::switch_t load_value,
  output board_pkg::count_t  count
);

  import board_pkg::*;

  count_t count_q;
  count_t count_next;
  count_t load_ext;

  // Switches land in the low bits, upper bits cleared
  assign load_ext = count_t'(load_value);

  // ==================================================================
  // Next value
  // ==================================================================
  always_comb begin
    count_next = count_q;
    if (load) begin
      count_next = load_ext;
    end else if (inc) begin
      // Wraps from FFFFFF to 0
      count_next = count_q + count_t'(1);
    end else if (dec) begin
      // Wraps from 0 to FFFFFF
      count_next = count_q - count_t'(1);
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_next;
    end
  end

  assign count = count_q;

endmodule : event_counter

`default_nettype wire

/* hdl/key_debouncer.sv */
// ==================================================================
// Push key debouncer
// Synchronizes one raw key input, accepts a new level only after it
// has held for DEBOUNCE_CYCLES clocks and reports accepted edges as
// single-cycle rise and fall pulses
// ==================================================================

`timescale 1ns/1ps
`default_nettype none

module key_debouncer #(
  parameter int DEBOUNCE_CYCLES = 500000
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  key_raw,
  output logic key_level,
  output logic key_rise,
  output logic key_fall
);

  import board_pkg::*;

  // Counter only has to reach DEBOUNCE_CYCLES - 1
  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  logic             key_meta;
  logic             key_sync;
  logic [CNT_W-1:0] settle_cnt;
  dbc_state_t       state;

  // Two-flop synchronizer, idles at released level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_meta <= 1'b1;
      key_sync <= 1'b1;
    end else begin
      key_meta <= key_raw;
      key_sync <= key_meta;
    end
  end

  // ==================================================================
  // Settle filter
  // ==================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= dbc_stable;
      settle_cnt <= '0;
      key_level  <= 1'b1;
      key_rise   <= 1'b0;
      key_fall   <= 1'b0;
    end else begin
      key_rise <= 1'b0;
      key_fall <= 1'b0;
      case (state)
        dbc_stable: begin
          settle_cnt <= CNT_W'(1);
          if (key_sync != key_level) begin
            state <= dbc_settling;
          end
        end
        dbc_settling: begin
          if (key_sync == key_level) begin
            // Bounced back before settling, drop it
            state <= dbc_stable;
          end else if (settle_cnt >= CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            state     <= dbc_stable;
            key_level <= key_sync;
            key_rise  <= key_sync;
            key_fall  <= ~key_sync;
          end else begin
            settle_cnt <= settle_cnt + CNT_W'(1);
          end
        end
        default: state <= dbc_stable;
      endcase
    end
  end

endmodule : key_debouncer

`default_nettype wire

/* hdl/reset_ctrl.sv */
// ==================================================================
// System reset control
// Asserts the system reset at once when the external reset, the
// reset key or the PLL lock drops, and releases it two clock
// edges after all three are high again
// ==================================================================

`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  button_rst_n,
  input  wire  pll_locked,
  output logic sys_rst_n
);

  logic arst_n;
  logic rst_meta;
  logic rst_sync;

  // Any source low pulls the chain down asynchronously
  assign arst_n = rst_n & button_rst_n & pll_locked;

  // Release synchronizer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_meta <= 1'b0;
      rst_sync <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rst_sync <= rst_meta;
    end
  end

  assign sys_rst_n = rst_sync;

endmodule : reset_ctrl

`default_nettype wire

/* hdl/seg7_encoder.sv */
// ==================================================================
// Seven-segment encoder
// Maps one hex digit to an active-low segment pattern, lower-case
// b and d, the rest upper case
// ==================================================================

`timescale 1ns/1ps
`default_nettype none

module seg7_encoder (
  input  board_pkg::digit_t digit,
  output board_pkg::seg_t   seg
);

  // Patterns listed as gfedcba, 0 lights a segment
  always_comb begin
    case (digit)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'ha:    seg = 7'b0001000;
      // Lower-case b
      4'hb:    seg = 7'b0000011;
      4'hc:    seg = 7'b1000110;
      // Lower-case d
      4'hd:    seg = 7'b0100001;
      4'he:    seg = 7'b0000110;
      4'hf:    seg = 7'b0001110;
      default: seg = 7'b1111111;
    endcase
  end

endmodule : seg7_encoder

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the board control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=board_ctrl_sim

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --top-module board_ctrl_tb \
  -f board_ctrl_top.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Test failed, see $LOG"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Test passed"
exit 0

/* verification/board_ctrl_stimulus.txt */
# Columns: command letter, then hex values. P key n | G key cycles | S switches
# L lock-drop cycles | R reset key | H key hold | I idle check | C expected count
I
C 000000
P 0 5
C 000005
G 0 3
G 0 7
G 0 1
C 000005
H 0
C 000006
P 1 6
C 000000
P 1 1
C FFFFFF
P 0 1
C 000000
S 3FF
P 2 1
C 0003FF
P 0 2
C 000401
L 4
C 000000
P 0 3
C 000003
R
C 000000
P 0 1
C 000001
S 2A5
P 2 1
C 0002A5
G 1 5
H 1
C 0002A4

/* verification/board_ctrl_tb.sv */
// ======================================================================
// Board control testbench
// Replays the stimulus file against board_ctrl_top, keeps a reference
// count and compares the hex displays and LEDs with it
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module board_ctrl_tb;

  import board_pkg::*;

  localparam int    DEBOUNCE_CYCLES = 8;
  localparam int    SETTLE_CYCLES   = 2 * DEBOUNCE_CYCLES + 10;
  localparam int    ACTION_CYCLES   = 4 * DEBOUNCE_CYCLES + 50;
  localparam string STIM_FILE       = "verification/board_ctrl_stimulus.txt";

  logic          clk;
  logic          rst_n;
  logic          pll_locked;
  logic [3:0]    key;
  switch_t       sw;
  seg_t          hex_out [6];
  logic [9:0]    ledr;

  integer        seed = 32'h2675bdba;
  int            fd;
  int            watchdog_cycles;
  count_t        model_count;

  board_ctrl_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_board_ctrl_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .pll_locked (pll_locked),
    .key        (key),
    .sw         (sw),
    .hex0       (hex_out[0]),
    .hex1       (hex_out[1]),
    .hex2       (hex_out[2]),
    .hex3       (hex_out[3]),
    .hex4       (hex_out[4]),
    .hex5       (hex_out[5]),
    .ledr       (ledr)
  );

  always #5 clk = ~clk;

  // ======================================================================
  // Checking and failure paths
  // ======================================================================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "Mismatch");
    end
  endtask

  // Reference segment table as gfedcba with 0 lit
  function automatic seg_t seg_pattern(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  task automatic check_display();
    for (int d = 0; d < 6; d++) begin
      check_value($sformatf("hex%0d", d), 32'(hex_out[d]),
                  32'(seg_pattern(model_count[d*4 +: 4])));
    end
  endtask

  task automatic check_idle();
    check_display();
    check_value("ledr[0]", 32'(ledr[0]), 32'd1);
    check_value("ledr[3:1]", 32'(ledr[3:1]), 32'd0);
    check_value("ledr[9:4]", 32'(ledr[9:4]), 32'd0);
  endtask

  // ======================================================================
  // Stimulus helpers
  // ======================================================================
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Bounce span always shorter than the filter window
  task automatic random_span(output int n);
    n = 1 + int'($unsigned($random(seed)) % (DEBOUNCE_CYCLES - 2));
  endtask

  task automatic bounce_key(input int k, input logic level);
    int toggles;
    int span;
    toggles = int'($unsigned($random(seed)) % 4);
    for (int i = 0; i < toggles; i++) begin
      key[k] = level;
      random_span(span);
      wait_cycles(span);
      key[k] = ~level;
      random_span(span);
      wait_cycles(span);
    end
    key[k] = level;
  endtask

  // Reference model of one accepted press
  task automatic apply_press(input int k);
    case (k)
      0: model_count = model_count + count_t'(1);
      1: model_count = model_count - count_t'(1);
      2: model_count = count_t'(sw);
      default: model_count = '0;
    endcase
  endtask

  task automatic press_key(input int k);
    bounce_key(k, 1'b0);
    wait_cycles(SETTLE_CYCLES);
    bounce_key(k, 1'b1);
    wait_cycles(SETTLE_CYCLES);
    apply_press(k);
  endtask

  task automatic glitch_key(input int k, input int cycles);
    key[k] = 1'b0;
    wait_cycles(cycles);
    key[k] = 1'b1;
    wait_cycles(SETTLE_CYCLES);
  endtask

  task automatic hold_key(input int k);
    key[k] = 1'b0;
    wait_cycles(SETTLE_CYCLES);
    check_value($sformatf("ledr[%0d]", k + 1), 32'(ledr[k+1]), 32'd1);
    key[k] = 1'b1;
    wait_cycles(SETTLE_CYCLES);
    check_value($sformatf("ledr[%0d]", k + 1), 32'(ledr[k+1]), 32'd0);
    apply_press(k);
  endtask

  task automatic drop_lock(input int cycles);
    pll_locked = 1'b0;
    wait_cycles(cycles);
    check_value("ledr[0]", 32'(ledr[0]), 32'd0);
    model_count = '0;
    pll_locked = 1'b1;
    wait_cycles(SETTLE_CYCLES);
    check_value("ledr[0]", 32'(ledr[0]), 32'd1);
  endtask

  task automatic hold_reset_key();
    key[3] = 1'b0;
    wait_cycles(SETTLE_CYCLES);
    check_value("ledr[0]", 32'(ledr[0]), 32'd0);
    model_count = '0;
    key[3] = 1'b1;
    wait_cycles(SETTLE_CYCLES);
    check_value("ledr[0]", 32'(ledr[0]), 32'd1);
  endtask

  // ======================================================================
  // Stimulus file parsing
  // ======================================================================
  task automatic read_command(output logic [7:0] cmd, output int arg_a,
                              output int arg_b, output bit got_cmd);
    int code;
    int ch;
    int n_args;
    bit searching;
    searching = 1'b1;
    got_cmd   = 1'b0;
    arg_a     = 0;
    arg_b     = 0;
    n_args    = 0;
    while (searching) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        searching = 1'b0;
      end else if (cmd == "#") begin
        // Skip the rest of a comment line
        ch = 0;
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        searching = 1'b0;
        got_cmd   = 1'b1;
      end
    end
    if (got_cmd) begin
      case (cmd)
        "P", "G": n_args = 2;
        "S", "L", "C", "H": n_args = 1;
        "I", "R": n_args = 0;
        default: abort_run($sformatf("Unknown command %c in the stimulus file", cmd));
      endcase
      if (n_args >= 1 && $fscanf(fd, "%h", arg_a) != 1) begin
        abort_run($sformatf("Missing value after command %c in the stimulus file", cmd));
      end
      if (n_args == 2 && $fscanf(fd, "%h", arg_b) != 1) begin
        abort_run($sformatf("Missing second value after command %c", cmd));
      end
    end
  endtask

  task automatic open_stimulus();
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end
  endtask

  // Weighted action count sets the watchdog limit
  task automatic size_watchdog();
    logic [7:0] cmd;
    int         arg_a;
    int         arg_b;
    bit         got_cmd;
    int         actions;
    actions = 1;
    open_stimulus();
    got_cmd = 1'b1;
    while (got_cmd) begin
      read_command(cmd, arg_a, arg_b, got_cmd);
      if (got_cmd) begin
        if (cmd == "P") begin
          actions += 2 * arg_b;
        end else if (cmd == "H") begin
          actions += 2;
        end else begin
          actions += 1;
        end
      end
    end
    $fclose(fd);
    watchdog_cycles = actions * ACTION_CYCLES;
  endtask

  task automatic run_command(input logic [7:0] cmd, input int arg_a, input int arg_b);
    if ((cmd == "P" || cmd == "H") && arg_a > 2) begin
      abort_run("Key index above 2 in a press or hold command");
    end
    case (cmd)
      "P": begin
        for (int i = 0; i < arg_b; i++) begin
          press_key(arg_a);
        end
      end
      "G": glitch_key(arg_a, arg_b);
      "S": sw = switch_t'(arg_a);
      "L": drop_lock(arg_a);
      "R": hold_reset_key();
      "H": hold_key(arg_a);
      "I": check_idle();
      default: begin
        check_value("reference count", 32'(model_count), 32'(arg_a));
        check_display();
      end
    endcase
  endtask

  initial begin : watchdog
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("Timeout: the stimulus did not finish within the cycle limit");
  end

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin : stimulus
    logic [7:0] cmd;
    int         arg_a;
    int         arg_b;
    bit         got_cmd;
    clk             = 1'b0;
    rst_n           = 1'b0;
    pll_locked      = 1'b1;
    key             = 4'hf;
    sw              = '0;
    watchdog_cycles = 0;
    model_count     = '0;
    size_watchdog();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_cycles(SETTLE_CYCLES);
    open_stimulus();
    got_cmd = 1'b1;
    while (got_cmd) begin
      read_command(cmd, arg_a, arg_b, got_cmd);
      if (got_cmd) begin
        run_command(cmd, arg_a, arg_b);
      end
    end
    $fclose(fd);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
